// File: logic/mat_ctrl_pkg.sv
package mat_ctrl_pkg;

    // ==============================================
    // widths and sizes
    // ==============================================
    localparam int DIM_W     = 8;
    localparam int ADDR_W    = 9;
    localparam int MAX_TYPES = 25;
    localparam int TYPE_W    = 5;
    localparam int CNT_W     = 2;
    localparam int TOTAL_W   = 8;

    // per-shape slot count tops out here
    localparam int CNT_MAX   = 2;

    // ==============================================
    // types
    // ==============================================
    typedef logic [ADDR_W-1:0] addr_t;

    typedef struct packed {
        logic [DIM_W-1:0] m;
        logic [DIM_W-1:0] n;
    } shape_t;

    typedef enum logic [2:0] {
        OP_TRANSPOSE = 3'd0,
        OP_ADD       = 3'd1,
        OP_MATMUL    = 3'd3
    } op_e;

    // shape plus matrix id within that shape
    typedef struct packed {
        shape_t     shape;
        logic [1:0] id;
    } operand_t;

    typedef struct packed {
        op_e    op;
        addr_t  op1_addr;
        addr_t  op2_addr;
        shape_t op1_shape;
        shape_t op2_shape;
        addr_t  res_addr;
    } calc_req_t;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_STORE   = 3'd1,
        ST_OPERAND = 3'd2,
        ST_CHECK   = 3'd3,
        ST_EXEC    = 3'd4,
        ST_DONE    = 3'd5,
        ST_ERROR   = 3'd6
    } state_e;

endpackage

// File: logic/btn_pulse.sv
`timescale 1ns/1ps

module btn_pulse (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] i_btn,
    output logic       o_confirm,
    output logic       o_menu
);

    // bit 0 is confirm, bit 1 is menu
    logic [1:0] btn_raw;
    logic [1:0] sync_a;
    logic [1:0] sync_b;
    logic [1:0] btn_last;
    logic [1:0] pulse;

    assign btn_raw = {i_btn[2], i_btn[0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_a   <= '0;
            sync_b   <= '0;
            btn_last <= '0;
            pulse    <= '0;
        end else begin
            sync_a   <= btn_raw;
            sync_b   <= sync_a;
            btn_last <= sync_b;
            // rising edge only, one cycle wide
            pulse    <= sync_b & ~btn_last;
        end
    end

    assign o_confirm = pulse[0];
    assign o_menu    = pulse[1];

endmodule

// File: logic/shape_ledger.sv
`timescale 1ns/1ps

module shape_ledger import mat_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  shape_t             i_query,
    input  logic               i_commit,
    output logic               o_hit,
    output logic [TYPE_W-1:0]  o_hit_idx,
    output logic [CNT_W-1:0]   o_hit_cnt,
    output addr_t              o_hit_start,
    output addr_t              o_slot_addr,
    output logic               o_full,
    output logic [TYPE_W-1:0]  o_types_count,
    output logic [TOTAL_W-1:0] o_total_count
);

    shape_t               tbl_shape [MAX_TYPES];
    addr_t                tbl_start [MAX_TYPES];
    logic [CNT_W-1:0]     tbl_cnt   [MAX_TYPES];
    logic [MAX_TYPES-1:0] tbl_tog;
    logic [TYPE_W-1:0]    used;
    addr_t                free_ptr;
    logic [2*DIM_W-1:0]   area;
    addr_t                mat_size;

    // addresses wrap modulo the memory size
    assign area     = i_query.m * i_query.n;
    assign mat_size = area[ADDR_W-1:0];
    assign o_full   = (used == TYPE_W'(MAX_TYPES));

    // ==============================================
    // lookup
    // ==============================================
    always_comb begin
        o_hit     = 1'b0;
        o_hit_idx = '0;
        for (int i = 0; i < MAX_TYPES; i++) begin
            if ((TYPE_W'(i) < used) && (tbl_shape[i] == i_query)) begin
                o_hit     = 1'b1;
                o_hit_idx = TYPE_W'(i);
            end
        end
    end

    assign o_hit_cnt   = tbl_cnt[o_hit_idx];
    assign o_hit_start = tbl_start[o_hit_idx];

    // toggle set means the second slot is next
    always_comb begin
        if (!o_hit) begin
            o_slot_addr = free_ptr;
        end else if (tbl_tog[o_hit_idx]) begin
            o_slot_addr = o_hit_start + mat_size;
        end else begin
            o_slot_addr = o_hit_start;
        end
    end

    // ==============================================
    // commit
    // ==============================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            used     <= '0;
            free_ptr <= '0;
            tbl_tog  <= '0;
            for (int i = 0; i < MAX_TYPES; i++) begin
                tbl_cnt[i] <= '0;
            end
        end else if (i_commit) begin
            if (o_hit) begin
                tbl_tog[o_hit_idx] <= ~tbl_tog[o_hit_idx];
                if (o_hit_cnt < CNT_W'(CNT_MAX)) begin
                    tbl_cnt[o_hit_idx] <= o_hit_cnt + 1'b1;
                end
            end else if (!o_full) begin
                tbl_tog[used] <= 1'b1;
                tbl_cnt[used] <= CNT_W'(1);
                free_ptr      <= free_ptr + (mat_size << 1);
                used          <= used + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_commit && !o_hit && !o_full) begin
            tbl_shape[used] <= i_query;
            tbl_start[used] <= free_ptr;
        end
    end

    // totals
    always_comb begin
        o_total_count = '0;
        for (int i = 0; i < MAX_TYPES; i++) begin
            if (TYPE_W'(i) < used) begin
                o_total_count = o_total_count + TOTAL_W'(tbl_cnt[i]);
            end
        end
    end

    assign o_types_count = used;

endmodule

// File: logic/op_planner.sv
`timescale 1ns/1ps

module op_planner import mat_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      i_load_op,
    input  op_e       i_op,
    input  logic      i_load_operand,
    input  shape_t    i_operand_shape,
    input  addr_t     i_operand_addr,
    output logic      o_need_more,
    output shape_t    o_res_shape,
    output logic      o_valid_op,
    output logic      o_fits,
    output calc_req_t o_req
);

    op_e        op_q;
    logic [1:0] n_loaded;
    logic [1:0] n_needed;
    shape_t     op1_shape;
    shape_t     op2_shape;
    addr_t      op1_addr;
    addr_t      op2_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q     <= OP_TRANSPOSE;
            n_loaded <= '0;
        end else if (i_load_op) begin
            op_q     <= i_op;
            n_loaded <= '0;
        end else if (i_load_operand && (n_loaded != 2'd2)) begin
            n_loaded <= n_loaded + 1'b1;
        end
    end

    // op2 is zeroed for single-operand ops
    always_ff @(posedge clk) begin
        if (i_load_op) begin
            op2_shape <= '0;
            op2_addr  <= '0;
        end else if (i_load_operand) begin
            if (n_loaded == 2'd0) begin
                op1_shape <= i_operand_shape;
                op1_addr  <= i_operand_addr;
            end else begin
                op2_shape <= i_operand_shape;
                op2_addr  <= i_operand_addr;
            end
        end
    end

    assign n_needed    = (op_q == OP_TRANSPOSE) ? 2'd1 : 2'd2;
    assign o_need_more = (n_loaded < n_needed);

    always_comb begin
        o_valid_op  = 1'b1;
        o_fits      = 1'b1;
        o_res_shape = op1_shape;
        case (op_q)
            OP_TRANSPOSE: begin
                o_res_shape.m = op1_shape.n;
                o_res_shape.n = op1_shape.m;
            end
            OP_ADD: o_fits = (op1_shape == op2_shape);
            OP_MATMUL: begin
                o_res_shape.n = op2_shape.n;
                o_fits        = (op1_shape.n == op2_shape.m);
            end
            default: begin
                o_valid_op = 1'b0;
                o_fits     = 1'b0;
            end
        endcase
    end

    assign o_req = '{op: op_q, op1_addr: op1_addr, op2_addr: op2_addr,
                     op1_shape: op1_shape, op2_shape: op2_shape, res_addr: '0};

endmodule

// File: logic/ctrl_fsm.sv
`timescale 1ns/1ps

module ctrl_fsm import mat_ctrl_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [7:0]       i_sw,
    input  logic             i_confirm,
    input  logic             i_menu,
    input  logic             i_dims_valid,
    input  operand_t         i_dims,
    output logic             o_dims_ready,
    output logic             o_addr_valid,
    output addr_t            o_addr,
    input  logic             i_rx_done,
    output logic             o_calc_valid,
    output calc_req_t        o_calc_req,
    input  logic             i_calc_ready,
    input  logic             i_calc_done,
    output shape_t           o_query,
    output logic             o_commit,
    input  logic             i_hit,
    input  logic [CNT_W-1:0] i_hit_cnt,
    input  addr_t            i_hit_start,
    input  addr_t            i_slot_addr,
    input  logic             i_full,
    output logic             o_load_op,
    output op_e              o_op,
    output logic             o_load_operand,
    output shape_t           o_operand_shape,
    output addr_t            o_operand_addr,
    input  logic             i_need_more,
    input  shape_t           i_res_shape,
    input  logic             i_valid_op,
    input  logic             i_fits,
    input  calc_req_t        i_req,
    output logic             o_logic_error,
    output state_e           o_state
);

    state_e               state;
    state_e               state_nx;
    logic                 dims_fire;
    logic                 operand_ok;
    logic                 calc_finish;
    logic [2*DIM_W-1:0]   area;
    logic [2*DIM_W+1:0]   id_offset;
    addr_t                res_addr_q;

    // ledger sees the incoming shape while taking beats, else the result shape
    assign o_query = (state == ST_STORE || state == ST_OPERAND) ? i_dims.shape : i_res_shape;

    always_comb begin
        case (state)
            ST_STORE:   o_dims_ready = i_hit || !i_full;
            ST_OPERAND: o_dims_ready = i_valid_op && i_need_more;
            default:    o_dims_ready = 1'b0;
        endcase
    end

    assign dims_fire   = i_dims_valid && o_dims_ready;
    assign calc_finish = (state == ST_EXEC) && !o_calc_valid && i_calc_done;

    // operand address is start + (id-1)*m*n
    assign area            = i_dims.shape.m * i_dims.shape.n;
    assign id_offset       = area * (i_dims.id - 2'd1);
    assign operand_ok      = i_hit && (i_dims.id != 2'd0) && (i_dims.id <= i_hit_cnt);
    assign o_operand_shape = i_dims.shape;
    assign o_operand_addr  = i_hit_start + id_offset[ADDR_W-1:0];
    assign o_load_operand  = (state == ST_OPERAND) && dims_fire && operand_ok;

    assign o_load_op = (state == ST_IDLE) && i_confirm && (i_sw[1:0] == 2'b10);
    assign o_op      = op_e'(i_sw[7:5]);
    assign o_commit  = ((state == ST_STORE) && dims_fire) || calc_finish;

    // ==============================================
    // next state
    // ==============================================
    always_comb begin
        state_nx = state;
        if (i_menu) begin
            state_nx = ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_confirm && i_sw[1:0] == 2'b00) begin
                        state_nx = ST_STORE;
                    end else if (o_load_op) begin
                        state_nx = ST_OPERAND;
                    end
                end
                ST_STORE:   if (i_rx_done) state_nx = ST_IDLE;
                ST_OPERAND: begin
                    if (!i_valid_op) begin
                        state_nx = ST_ERROR;
                    end else if (!i_need_more) begin
                        state_nx = ST_CHECK;
                    end
                end
                // result needs an existing entry or room for a new one
                ST_CHECK:   state_nx = (i_fits && (i_hit || !i_full)) ? ST_EXEC : ST_ERROR;
                ST_EXEC:    if (calc_finish) state_nx = ST_DONE;
                ST_DONE,
                ST_ERROR:   if (i_confirm) state_nx = ST_IDLE;
                default:    state_nx = ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            o_addr_valid  <= 1'b0;
            o_calc_valid  <= 1'b0;
            o_logic_error <= 1'b0;
        end else begin
            state        <= state_nx;
            o_addr_valid <= (state == ST_STORE) && dims_fire;

            if (state == ST_CHECK && state_nx == ST_EXEC) begin
                o_calc_valid <= 1'b1;
            end else if (i_calc_ready || state_nx == ST_IDLE) begin
                o_calc_valid <= 1'b0;
            end

            if (state_nx == ST_IDLE) begin
                o_logic_error <= 1'b0;
            end else if (state_nx == ST_ERROR) begin
                o_logic_error <= 1'b1;
            end else if (state == ST_OPERAND && dims_fire) begin
                o_logic_error <= !operand_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_STORE && dims_fire) begin
            o_addr <= i_slot_addr;
        end
        if (state == ST_CHECK) begin
            res_addr_q <= i_slot_addr;
        end
    end

    always_comb begin
        o_calc_req          = i_req;
        o_calc_req.res_addr = res_addr_q;
    end

    assign o_state = state;

endmodule

// File: logic/mat_ctrl_top.sv
`timescale 1ns/1ps

module mat_ctrl_top import mat_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [7:0]         i_sw,
    input  logic [2:0]         i_btn,
    input  logic               i_dims_valid,
    input  operand_t           i_dims,
    output logic               o_dims_ready,
    output logic               o_addr_valid,
    output addr_t              o_addr,
    input  logic               i_rx_done,
    output logic               o_calc_valid,
    output calc_req_t          o_calc_req,
    input  logic               i_calc_ready,
    input  logic               i_calc_done,
    output logic               o_logic_error,
    output state_e             o_state,
    output logic [TYPE_W-1:0]  o_types_count,
    output logic [TOTAL_W-1:0] o_total_count
);

    logic             confirm;
    logic             menu;
    shape_t           query;
    logic             commit;
    logic             hit;
    logic [CNT_W-1:0] hit_cnt;
    addr_t            hit_start;
    addr_t            slot_addr;
    logic             full;
    logic             load_op;
    op_e              op;
    logic             load_operand;
    shape_t           operand_shape;
    addr_t            operand_addr;
    logic             need_more;
    shape_t           res_shape;
    logic             valid_op;
    logic             fits;
    calc_req_t        plan_req;

    btn_pulse u_btn (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_btn     (i_btn),
        .o_confirm (confirm),
        .o_menu    (menu)
    );

    // entry index is for debug visibility only
    shape_ledger u_ledger (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_query       (query),
        .i_commit      (commit),
        .o_hit         (hit),
        .o_hit_idx     (),
        .o_hit_cnt     (hit_cnt),
        .o_hit_start   (hit_start),
        .o_slot_addr   (slot_addr),
        .o_full        (full),
        .o_types_count (o_types_count),
        .o_total_count (o_total_count)
    );

    op_planner u_planner (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_load_op       (load_op),
        .i_op            (op),
        .i_load_operand  (load_operand),
        .i_operand_shape (operand_shape),
        .i_operand_addr  (operand_addr),
        .o_need_more     (need_more),
        .o_res_shape     (res_shape),
        .o_valid_op      (valid_op),
        .o_fits          (fits),
        .o_req           (plan_req)
    );

    ctrl_fsm u_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_sw            (i_sw),
        .i_confirm       (confirm),
        .i_menu          (menu),
        .i_dims_valid    (i_dims_valid),
        .i_dims          (i_dims),
        .o_dims_ready    (o_dims_ready),
        .o_addr_valid    (o_addr_valid),
        .o_addr          (o_addr),
        .i_rx_done       (i_rx_done),
        .o_calc_valid    (o_calc_valid),
        .o_calc_req      (o_calc_req),
        .i_calc_ready    (i_calc_ready),
        .i_calc_done     (i_calc_done),
        .o_query         (query),
        .o_commit        (commit),
        .i_hit           (hit),
        .i_hit_cnt       (hit_cnt),
        .i_hit_start     (hit_start),
        .i_slot_addr     (slot_addr),
        .i_full          (full),
        .o_load_op       (load_op),
        .o_op            (op),
        .o_load_operand  (load_operand),
        .o_operand_shape (operand_shape),
        .o_operand_addr  (operand_addr),
        .i_need_more     (need_more),
        .i_res_shape     (res_shape),
        .i_valid_op      (valid_op),
        .i_fits          (fits),
        .i_req           (plan_req),
        .o_logic_error   (o_logic_error),
        .o_state         (o_state)
    );

endmodule

// File: dv/mat_ctrl_checker.sv
`timescale 1ns/1ps

module mat_ctrl_checker import mat_ctrl_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      i_dims_valid,
    input logic      o_dims_ready,
    input logic      o_addr_valid,
    input logic      o_calc_valid,
    input calc_req_t o_calc_req,
    input logic      i_calc_ready
);

    int fail_count = 0;

    // ==============================================
    // handshake rules
    // ==============================================
    a_calc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_calc_valid && !i_calc_ready |=> o_calc_valid && $stable(o_calc_req))
    else begin
        fail_count++;
        $error("calc request changed or dropped before ready");
    end

    // address reply follows a dims transfer by one cycle
    a_addr_after_dims: assert property (@(posedge clk) disable iff (!rst_n)
        o_addr_valid |-> $past(i_dims_valid && o_dims_ready))
    else begin
        fail_count++;
        $error("address reply without a dims transfer");
    end

    a_ready_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_dims_ready && o_calc_valid))
    else begin
        fail_count++;
        $error("dims ready and calc valid high together");
    end

endmodule

bind mat_ctrl_top mat_ctrl_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_dims_valid (i_dims_valid),
    .o_dims_ready (o_dims_ready),
    .o_addr_valid (o_addr_valid),
    .o_calc_valid (o_calc_valid),
    .o_calc_req   (o_calc_req),
    .i_calc_ready (i_calc_ready)
);

// File: dv/tb_mat_ctrl.sv
`timescale 1ns/1ps

module tb_mat_ctrl import mat_ctrl_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int BTN_HOLD       = 6;
    localparam int STATE_WAIT     = 40;

    logic               clk;
    logic               rst_n;
    logic [7:0]         i_sw;
    logic [2:0]         i_btn;
    logic               i_dims_valid;
    operand_t           i_dims;
    logic               o_dims_ready;
    logic               o_addr_valid;
    addr_t              o_addr;
    logic               i_rx_done;
    logic               o_calc_valid;
    calc_req_t          o_calc_req;
    logic               i_calc_ready;
    logic               i_calc_done;
    logic               o_logic_error;
    state_e             o_state;
    logic [TYPE_W-1:0]  o_types_count;
    logic [TOTAL_W-1:0] o_total_count;

    int          checks;
    int          errors;
    int          test_base;
    int          cycles;
    logic [31:0] lcg_state;

    mat_ctrl_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================================
    // helpers and compare tasks
    // ==============================================
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic int rand_below(input int limit);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16]) % limit;
    endfunction

    function automatic shape_t make_shape(input int m, input int n);
        shape_t s;
        s.m = DIM_W'(m);
        s.n = DIM_W'(n);
        return s;
    endfunction

    function automatic operand_t make_operand(input shape_t s, input logic [1:0] id);
        operand_t o;
        o.shape = s;
        o.id    = id;
        return o;
    endfunction

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_req(input calc_req_t got, input calc_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED o_calc_req: got 0x%0h, expected 0x%0h", got, exp);
        end
    endtask

    task automatic compare_count(input string name, input logic [TOTAL_W-1:0] got,
                                 input logic [TOTAL_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_state(input state_e got, input state_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED o_state: got 0x%0h, expected 0x%0h", got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        if (errors == test_base) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d mismatches", name, errors - test_base);
        end
        test_base = errors;
    endtask

    // ==============================================
    // drivers
    // ==============================================
    task automatic press_button(input int idx);
        i_btn[idx] = 1'b1;
        repeat (BTN_HOLD) tick();
        i_btn[idx] = 1'b0;
        tick();
    endtask

    // returns on a falling edge, state checked there
    task automatic wait_state(input state_e target);
        int n;
        n = 0;
        @(negedge clk);
        while (o_state !== target && n < STATE_WAIT) begin
            @(negedge clk);
            n++;
        end
        compare_state(o_state, target);
    endtask

    task automatic send_dims(input operand_t beat);
        i_dims_valid = 1'b1;
        i_dims       = beat;
        @(negedge clk);
        while (!o_dims_ready) begin
            @(negedge clk);
        end
        tick();
        i_dims_valid = 1'b0;
        i_dims       = '0;
    endtask

    task automatic store_shape(input shape_t s, input addr_t exp);
        send_dims(make_operand(s, 2'd0));
        @(negedge clk);
        compare_flag("o_addr_valid", o_addr_valid, 1'b1);
        compare_addr("o_addr", o_addr, exp);
        tick();
    endtask

    task automatic enter_store();
        i_sw = 8'h00;
        press_button(0);
        wait_state(ST_STORE);
        tick();
    endtask

    task automatic end_store();
        i_rx_done = 1'b1;
        tick();
        i_rx_done = 1'b0;
        wait_state(ST_IDLE);
    endtask

    task automatic enter_calc(input logic [2:0] code);
        i_sw = {code, 3'b000, 2'b10};
        press_button(0);
    endtask

    task automatic leave_with_confirm();
        tick();
        press_button(0);
        wait_state(ST_IDLE);
        tick();
    endtask

    // acts as the calculator core
    task automatic run_core(input calc_req_t exp);
        int delay;
        @(negedge clk);
        while (!o_calc_valid) begin
            @(negedge clk);
        end
        compare_req(o_calc_req, exp);
        tick();
        delay = rand_below(4);
        repeat (delay) tick();
        i_calc_ready = 1'b1;
        tick();
        i_calc_ready = 1'b0;
        delay = rand_below(5);
        repeat (delay) tick();
        i_calc_done = 1'b1;
        tick();
        i_calc_done = 1'b0;
    endtask

    // ==============================================
    // tests
    // ==============================================
    task automatic test_store_alloc();
        @(negedge clk);
        compare_state(o_state, ST_IDLE);
        compare_flag("o_dims_ready", o_dims_ready, 1'b0);
        compare_flag("o_addr_valid", o_addr_valid, 1'b0);
        compare_flag("o_calc_valid", o_calc_valid, 1'b0);
        compare_flag("o_logic_error", o_logic_error, 1'b0);
        tick();
        enter_store();
        store_shape(make_shape(2, 3), addr_t'(0));
        // past both 2x3 slots
        store_shape(make_shape(3, 2), addr_t'(2 * 2 * 3));
        end_store();
        compare_count("o_types_count", TOTAL_W'(o_types_count), 8'd2);
        tick();
        report_test("store allocation");
    endtask

    task automatic test_slot_toggle();
        enter_store();
        store_shape(make_shape(2, 3), addr_t'(6));
        store_shape(make_shape(2, 3), addr_t'(0));
        store_shape(make_shape(2, 3), addr_t'(6));
        end_store();
        // 2x3 saturated at 2 plus one 3x2
        compare_count("o_total_count", o_total_count, 8'd3);
        compare_count("o_types_count", TOTAL_W'(o_types_count), 8'd2);
        tick();
        report_test("slot toggling");
    endtask

    task automatic test_transpose();
        calc_req_t exp;
        enter_calc(3'd0);
        wait_state(ST_OPERAND);
        tick();
        send_dims(make_operand(make_shape(2, 3), 2'd2));
        // 3x2 entry starts at 12 with its toggle set, so slot two
        exp = '{op: OP_TRANSPOSE, op1_addr: addr_t'(6), op2_addr: '0,
                op1_shape: make_shape(2, 3), op2_shape: '0, res_addr: addr_t'(12 + 6)};
        run_core(exp);
        wait_state(ST_DONE);
        compare_count("o_total_count", o_total_count, 8'd4);
        leave_with_confirm();
        report_test("transpose");
    endtask

    task automatic test_check_rule();
        calc_req_t exp;
        enter_calc(3'd3);
        wait_state(ST_OPERAND);
        tick();
        send_dims(make_operand(make_shape(2, 3), 2'd1));
        send_dims(make_operand(make_shape(2, 3), 2'd1));
        wait_state(ST_ERROR);
        compare_flag("o_logic_error", o_logic_error, 1'b1);
        leave_with_confirm();
        compare_flag("o_logic_error", o_logic_error, 1'b0);
        enter_calc(3'd3);
        wait_state(ST_OPERAND);
        tick();
        send_dims(make_operand(make_shape(2, 3), 2'd1));
        send_dims(make_operand(make_shape(3, 2), 2'd2));
        // 2x2 is new, free pointer sits at 24
        exp = '{op: OP_MATMUL, op1_addr: addr_t'(0), op2_addr: addr_t'(12 + 6),
                op1_shape: make_shape(2, 3), op2_shape: make_shape(3, 2),
                res_addr: addr_t'(24)};
        run_core(exp);
        wait_state(ST_DONE);
        compare_count("o_types_count", TOTAL_W'(o_types_count), 8'd3);
        compare_count("o_total_count", o_total_count, 8'd5);
        leave_with_confirm();
        report_test("check rule");
    endtask

    task automatic test_bad_operands();
        enter_calc(3'd1);
        wait_state(ST_OPERAND);
        tick();
        send_dims(make_operand(make_shape(4, 4), 2'd1));
        @(negedge clk);
        compare_flag("o_logic_error", o_logic_error, 1'b1);
        compare_state(o_state, ST_OPERAND);
        tick();
        send_dims(make_operand(make_shape(2, 3), 2'd1));
        @(negedge clk);
        compare_flag("o_logic_error", o_logic_error, 1'b0);
        tick();
        send_dims(make_operand(make_shape(2, 3), 2'd0));
        @(negedge clk);
        compare_flag("o_logic_error", o_logic_error, 1'b1);
        compare_state(o_state, ST_OPERAND);
        tick();
        press_button(2);
        wait_state(ST_IDLE);
        compare_flag("o_logic_error", o_logic_error, 1'b0);
        tick();
        // code 2 is not an operation
        enter_calc(3'd2);
        wait_state(ST_ERROR);
        compare_flag("o_logic_error", o_logic_error, 1'b1);
        leave_with_confirm();
        report_test("bad operands and menu");
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        i_sw         = '0;
        i_btn        = '0;
        i_dims_valid = 1'b0;
        i_dims       = '0;
        i_rx_done    = 1'b0;
        i_calc_ready = 1'b0;
        i_calc_done  = 1'b0;
        rst_n        = 1'b0;
        checks       = 0;
        errors       = 0;
        test_base    = 0;
        lcg_state    = 32'h23566def;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_store_alloc();
        test_slot_toggle();
        test_transpose();
        test_check_rule();
        test_bad_operands();

        errors = errors + dut0.u_checker.fail_count;
        $display("checks run: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/mat_ctrl_pkg.sv
logic/btn_pulse.sv
logic/shape_ledger.sv
logic/op_planner.sv
logic/ctrl_fsm.sv
logic/mat_ctrl_top.sv
dv/mat_ctrl_checker.sv
dv/tb_mat_ctrl.sv

// File: Bender.yml
package:
  name: mat_ctrl

sources:
  - files:
      - logic/mat_ctrl_pkg.sv
      - logic/btn_pulse.sv
      - logic/shape_ledger.sv
      - logic/op_planner.sv
      - logic/ctrl_fsm.sv
      - logic/mat_ctrl_top.sv
  - target: test
    files:
      - dv/mat_ctrl_checker.sv
      - dv/tb_mat_ctrl.sv
